// ==== can_rx.f ====
+incdir+hw
hw/can_pkg.sv
hw/can_bit_destuff.sv
hw/can_crc15.sv
hw/can_field_sequencer.sv
hw/can_frame_capture.sv
hw/can_rx.sv
dv/can_rx_tb.sv

// ==== dv/can_rx_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "can_macros.svh"

module can_rx_tb;
	import can_pkg::*;

	// About 28 frames of up to 180 bits with idle gap, 4 clocks per bit
	localparam int cycle_limit = 28 * 180 * 4;
	localparam int wait_limit  = 400;   // Cycles to wait for one event

	logic      clock;
	logic      reset;
	logic      rx_bit;
	logic      sample_point;
	logic      frame_ack;
	logic      frame_req;
	id_a_t     id_a;
	id_b_t     id_b;
	logic      ide;
	logic      rtr;
	dlc_t      dlc_out;
	data_t     data_out;
	logic      overrun;
	logic      error_valid;
	err_kind_t error_kind;

	logic [31:0] rng = 32'h7bbd4c43;
	bit          raw[$];            // Unstuffed SOF through CRC
	bit          frame_bits[$];     // Bus bits as sent
	bit          hold_ack;          // Responder held off
	int          errors;
	int          tests;
	int          failed_tests;
	int          test_errors;
	int          cycles;
	int          req_seen;
	int          err_seen;
	int          ovr_seen;
	int          req_mark;
	int          err_mark;
	int          ovr_mark;
	err_kind_t   last_kind;
	logic        req_prev;

	can_rx can_rx_i (
		.clock        (clock),
		.reset        (reset),
		.rx_bit       (rx_bit),
		.sample_point (sample_point),
		.frame_ack    (frame_ack),
		.frame_req    (frame_req),
		.id_a         (id_a),
		.id_b         (id_b),
		.ide          (ide),
		.rtr          (rtr),
		.dlc_out      (dlc_out),
		.data_out     (data_out),
		.overrun      (overrun),
		.error_valid  (error_valid),
		.error_kind   (error_kind)
	);

	initial
	begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	// ====================
	// Handshake properties
	// ====================

	// No new request while the last ack is still up
	req_rise_check: assert property (@(posedge clock) disable iff (reset)
		$rose(frame_req) |-> !$past(frame_ack))
		else begin errors++; $display("frame_req rose while frame_ack was high"); end

	// Request gone before the ack is released
	ack_fall_check: assert property (@(posedge clock) disable iff (reset)
		$fell(frame_ack) |-> !frame_req)
		else begin errors++; $display("frame_ack released with frame_req still high"); end

	error_pulse_check: assert property (@(posedge clock) disable iff (reset)
		error_valid |=> !error_valid)
		else begin errors++; $display("error_valid longer than one cycle"); end

	overrun_pulse_check: assert property (@(posedge clock) disable iff (reset)
		overrun |=> !overrun)
		else begin errors++; $display("overrun longer than one cycle"); end

	// ====================
	// Monitor and limits
	// ====================

	always @(posedge clock)
	begin
		cycles++;
		if (cycles >= cycle_limit)
		begin
			$display("Timeout: run stopped after %0d cycles", cycles);
			$display("Finished with errors");
			$finish;
		end
	end

	// Event counters the tests wait on
	always @(posedge clock)
	begin
		if (!reset)
		begin
			if (error_valid)
			begin
				err_seen++;
				last_kind = error_kind;
			end
			if (frame_req && !req_prev)
				req_seen++;
			if (overrun)
				ovr_seen++;
		end
		req_prev = frame_req;
	end

	// Consumer side, random ack delay
	initial
	begin
		int d;
		forever
		begin
			@(posedge clock);
			if (frame_req && !hold_ack && !frame_ack)
			begin
				rng = xorshift(rng);
				d = int'(rng[3:0]);
				repeat (d) @(posedge clock);
				#5 frame_ack = 1'b1;
				@(posedge clock);
				#5 frame_ack = 1'b0;    // Request drops at the first edge with ack high
			end
		end
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// ====================
	// Frame builder
	// ====================

	task automatic build_frame(input bit ext, input logic [10:0] ida, input logic [17:0] idb,
		input bit rtr_b, input logic [3:0] dlc_v, input logic [63:0] data_v,
		input int flip_raw, input bit stuff_err, input bit ack_rec, input bit eof_dom);
		int          nbytes;
		logic [14:0] crc;
		bit          nxt;
		bit          last;
		int          run;
		int          first_stuff;
		raw.delete();
		frame_bits.delete();
		raw.push_back(1'b0);                        // SOF
		for (int i = 10; i >= 0; i--)
			raw.push_back(ida[i]);
		if (ext)
		begin
			raw.push_back(1'b1);                    // SRR
			raw.push_back(1'b1);                    // IDE
			for (int i = 17; i >= 0; i--)
				raw.push_back(idb[i]);
			raw.push_back(rtr_b);
			raw.push_back(1'b0);                    // r1
			raw.push_back(1'b0);                    // r0
		end
		else
		begin
			raw.push_back(rtr_b);
			raw.push_back(1'b0);                    // IDE
			raw.push_back(1'b0);                    // r0
		end
		for (int i = 3; i >= 0; i--)
			raw.push_back(dlc_v[i]);
		nbytes = rtr_b ? 0 : (dlc_v > 8 ? 8 : int'(dlc_v));
		for (int i = nbytes * 8 - 1; i >= 0; i--)
			raw.push_back(data_v[i]);
		// CRC-15 by the CAN generator polynomial
		crc = '0;
		foreach (raw[i])
		begin
			nxt = raw[i] ^ crc[14];
			crc = {crc[13:0], 1'b0};
			if (nxt)
				crc = crc ^ `CAN_CRC_POLY;
		end
		for (int i = 14; i >= 0; i--)
			raw.push_back(crc[i]);
		if (flip_raw >= 0)
			raw[flip_raw] = ~raw[flip_raw];         // CRC left as it was
		// Stuff bit after every five equal bits
		run = 0;
		last = 1'b0;
		first_stuff = -1;
		foreach (raw[i])
		begin
			frame_bits.push_back(raw[i]);
			if (run > 0 && raw[i] == last)
				run++;
			else
				run = 1;
			last = raw[i];
			if (run == `CAN_STUFF_RUN)
			begin
				if (first_stuff < 0)
					first_stuff = frame_bits.size();
				frame_bits.push_back(~last);
				last = ~last;
				run = 1;
			end
		end
		if (stuff_err && first_stuff >= 0)
			frame_bits[first_stuff] = ~frame_bits[first_stuff];   // Sixth equal bit
		frame_bits.push_back(1'b1);                 // CRC delimiter
		frame_bits.push_back(ack_rec);              // ACK slot
		frame_bits.push_back(1'b1);                 // ACK delimiter
		for (int i = 0; i < `CAN_LEN_EOF; i++)
			frame_bits.push_back(!(eof_dom && i == 3));
		for (int i = 0; i < `CAN_LEN_INTERMISSION; i++)
			frame_bits.push_back(1'b1);
	endtask

	// One bus bit, four clocks, sampled at the first edge
	task automatic send_bit(input bit b);
		@(posedge clock);
		#5;
		rx_bit = b;
		sample_point = 1'b1;
		@(posedge clock);
		#5 sample_point = 1'b0;
		repeat (2) @(posedge clock);
	endtask

	task automatic send_frame();
		foreach (frame_bits[i])
			send_bit(frame_bits[i]);
		repeat (12) send_bit(1'b1);     // Idle gap, also ends error recovery
	endtask

	// ====================
	// Checks and test steps
	// ====================

	task automatic check_hex(input string name, input logic [63:0] got, input logic [63:0] exp);
		assert (got == exp)
		else
		begin
			errors++;
			$display("Fail %s: got %h, expected %h", name, got, exp);
		end
	endtask

	// 0 waits for frame_req, 1 for an error, 2 for overrun
	task automatic wait_event(input int which, input string what);
		bit got;
		got = 1'b0;
		for (int n = 0; n < wait_limit && !got; n++)
		begin
			case (which)
				0: got = req_seen > req_mark;
				1: got = err_seen > err_mark;
				default: got = ovr_seen > ovr_mark;
			endcase
			if (!got)
				@(posedge clock);
		end
		assert (got)
		else
		begin
			errors++;
			$display("No %s within %0d cycles", what, wait_limit);
		end
	endtask

	task automatic start_test();
		req_mark = req_seen;
		err_mark = err_seen;
		ovr_mark = ovr_seen;
		test_errors = errors;
	endtask

	task automatic end_test(input string name);
		tests++;
		if (errors != test_errors)
			failed_tests++;
		$display("Test %0d %s: %s", tests, name, errors == test_errors ? "ok" : "failed");
	endtask

	function automatic logic [63:0] data_mask(input logic [63:0] d, input int nbytes);
		if (nbytes >= 8)
			return d;
		return d & ((64'h1 << (nbytes * 8)) - 64'h1);
	endfunction

	task automatic check_fields(input bit ext, input logic [10:0] ida, input logic [17:0] idb,
		input bit rtr_b, input logic [3:0] dlc_v, input logic [63:0] data_v);
		int nb;
		nb = dlc_v > 8 ? 8 : int'(dlc_v);
		check_hex("id_a", 64'(id_a), 64'(ida));
		check_hex("ide", 64'(ide), 64'(ext));
		if (ext)
			check_hex("id_b", 64'(id_b), 64'(idb));
		check_hex("rtr", 64'(rtr), 64'(rtr_b));
		check_hex("dlc_out", 64'(dlc_out), 64'(nb));
		check_hex("data_out", data_out, rtr_b ? 64'h0 : data_mask(data_v, nb));
	endtask

	// Good frame in, matching request out, no error
	task automatic good_frame(input string name, input bit ext, input logic [10:0] ida,
		input logic [17:0] idb, input bit rtr_b, input logic [3:0] dlc_v);
		logic [63:0] d;
		rng = xorshift(rng);
		d[63:32] = rng;
		rng = xorshift(rng);
		d[31:0] = rng;
		start_test();
		build_frame(ext, ida, idb, rtr_b, dlc_v, d, -1, 0, 0, 0);
		send_frame();
		wait_event(0, "frame_req");
		check_fields(ext, ida, idb, rtr_b, dlc_v, d);
		check_hex("error count", 64'(err_seen - err_mark), 64'h0);
		end_test(name);
	endtask

	// Broken base frame, one error report and no request
	task automatic bad_frame(input string name, input err_kind_t kind, input logic [10:0] ida,
		input int flip_raw, input bit stuff_err, input bit ack_rec, input bit eof_dom);
		start_test();
		rng = xorshift(rng);
		build_frame(0, ida, '0, 0, 4'd2, {32'h0, rng}, flip_raw, stuff_err, ack_rec, eof_dom);
		send_frame();
		wait_event(1, "error_valid");
		check_hex("error_kind", 64'(last_kind), 64'(kind));
		check_hex("error count", 64'(err_seen - err_mark), 64'h1);
		check_hex("frame_req count", 64'(req_seen - req_mark), 64'h0);
		end_test(name);
	endtask

	// ====================
	// Stimulus
	// ====================

	initial
	begin
		logic [10:0] ida;
		logic [63:0] da;
		reset = 1'b1;
		rx_bit = 1'b1;
		sample_point = 1'b0;
		frame_ack = 1'b0;
		hold_ack = 1'b0;
		repeat (2) @(posedge clock);
		#5 reset = 1'b0;
		repeat (4) send_bit(1'b1);

		for (int n = 0; n <= 8; n++)
		begin
			rng = xorshift(rng);
			good_frame($sformatf("base data dlc %0d", n), 0, rng[10:0], '0, 0, 4'(n));
		end
		rng = xorshift(rng);
		good_frame("extended data", 1, rng[10:0], rng[31:14], 0, 4'd5);
		rng = xorshift(rng);
		good_frame("extended data dlc 12", 1, rng[10:0], rng[31:14], 0, 4'd12);
		rng = xorshift(rng);
		good_frame("base remote", 0, rng[10:0], '0, 1, 4'd3);
		rng = xorshift(rng);
		good_frame("extended remote", 1, rng[10:0], rng[31:14], 1, 4'd8);
		good_frame("base data dlc 12", 0, 11'h2a5, '0, 0, 4'd12);

		// Zero ID forces a stuff bit in the identifier
		bad_frame("stuff error", err_stuff, 11'h000, -1, 1, 0, 0);
		rng = xorshift(rng);
		good_frame("recovery frame", 0, rng[10:0], '0, 0, 4'd4);
		bad_frame("crc error", err_crc, 11'h155, 22, 0, 0, 0);
		bad_frame("ack error", err_ack, 11'h0f3, -1, 0, 1, 0);
		bad_frame("form error", err_form, 11'h36c, -1, 0, 0, 1);

		// Back-to-back frames with the consumer stalled
		start_test();
		hold_ack = 1'b1;
		rng = xorshift(rng);
		ida = rng[10:0];
		rng = xorshift(rng);
		da = {rng, ~rng};
		build_frame(0, ida, '0, 0, 4'd8, da, -1, 0, 0, 0);
		send_frame();
		wait_event(0, "frame_req");
		rng = xorshift(rng);
		build_frame(0, rng[10:0], '0, 0, 4'd1, {32'h0, rng}, -1, 0, 0, 0);
		send_frame();
		wait_event(2, "overrun");
		check_hex("frame_req", 64'(frame_req), 64'h1);
		check_fields(0, ida, '0, 0, 4'd8, da);
		hold_ack = 1'b0;
		repeat (wait_limit)
		begin
			if (frame_req)
				@(posedge clock);
		end
		check_hex("frame_req after ack", 64'(frame_req), 64'h0);
		check_hex("overrun count", 64'(ovr_seen - ovr_mark), 64'h1);
		end_test("overrun");

		// Frame ends while the consumer still holds ack with no request up
		start_test();
		hold_ack = 1'b1;
		@(posedge clock);
		#5 frame_ack = 1'b1;
		rng = xorshift(rng);
		build_frame(0, rng[10:0], '0, 0, 4'd3, {32'h0, rng}, -1, 0, 0, 0);
		send_frame();
		wait_event(2, "overrun");
		check_hex("frame_req count", 64'(req_seen - req_mark), 64'h0);
		check_fields(0, ida, '0, 0, 4'd8, da);
		#5 frame_ack = 1'b0;
		hold_ack = 1'b0;
		end_test("ack held");

		repeat (20) @(posedge clock);
		$display("Tests: %0d, failed: %0d, errors: %0d", tests, failed_tests, errors);
		if (errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

`default_nettype wire

// ==== hw/can_bit_destuff.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "can_macros.svh"

module can_bit_destuff (
	input  logic clock,
	input  logic reset,
	input  logic rx_bit,
	input  logic sample_point,
	input  logic stuff_region,
	output logic data_strobe,
	output logic stuff_error,
	output logic bit_value
);

	// Last bus bits, stuff bits included
	logic [`CAN_STUFF_RUN-1:0] history;
	logic run_full;     // History is one level only
	logic run_level;    // Level of that run

	// ====================
	// Bit history
	// ====================

	// Shifts on every sample point, so stuff bits start a new run
	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			// Alternating start so no run is seen after reset
			for (int i = 0; i < `CAN_STUFF_RUN; i++)
			begin
				history[i] <= i[0];
			end
		end
		else if (sample_point)
			history <= {history[`CAN_STUFF_RUN-2:0], rx_bit};
	end

	// ====================
	// Classification
	// ====================

	assign run_full  = (&history) | ~(|history);
	assign run_level = history[0];

	assign bit_value = rx_bit;      // Raw sampled level

	// After a full run the bit is never a frame bit
	assign data_strobe = sample_point & ~(stuff_region & run_full);

	// Opposite level is the stuff bit, same level is a sixth equal bit
	assign stuff_error = sample_point & stuff_region & run_full & (rx_bit == run_level);

endmodule

`default_nettype wire

// ==== hw/can_crc15.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "can_macros.svh"

module can_crc15 (
	input  logic clock,
	input  logic reset,
	input  logic crc_clear,
	input  logic crc_shift,
	input  logic bit_value,
	output logic crc_zero
);
	import can_pkg::*;

	crc_t crc_q;        // Running remainder
	logic feedback;     // Incoming bit against the MSB
	crc_t crc_shifted;

	assign feedback    = bit_value ^ crc_q[`CAN_LEN_CRC-1];
	assign crc_shifted = {crc_q[`CAN_LEN_CRC-2:0], 1'b0};

	// Serial division by the CAN polynomial
	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
			crc_q <= '0;
		else if (crc_clear)
			crc_q <= '0;    // Held clear between frames
		else if (crc_shift)
		begin
			if (feedback)
				crc_q <= crc_shifted ^ `CAN_CRC_POLY;
			else
				crc_q <= crc_shifted;
		end
	end

	// Received CRC shifted in too, so a match leaves no remainder
	assign crc_zero = (crc_q == '0);

endmodule

`default_nettype wire

// ==== hw/can_field_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "can_macros.svh"

module can_field_sequencer (
	input  logic               clock,
	input  logic               reset,
	input  logic               sample_point,
	input  logic               bit_value,
	input  logic               data_strobe,
	input  logic               stuff_error,
	input  logic               crc_zero,
	output logic               stuff_region,
	output logic               crc_clear,
	output logic               crc_shift,
	output can_pkg::field_t    field,
	output logic               field_strobe,
	output logic               frame_start,
	output logic               frame_done,
	output can_pkg::dlc_t      dlc,
	output logic               error_valid,
	output can_pkg::err_kind_t error_kind
);
	import can_pkg::*;

	logic [5:0] bit_cnt;        // Shared bit counter for every field
	logic       rtr_q;          // Remote frame, no data field
	logic       bit_tick;       // One frame bit for the current field
	logic       field_last;     // Last bit of the current field
	field_t     next_field;
	dlc_t       dlc_shift;
	dlc_t       dlc_clamped;
	logic [6:0] data_bits;      // Data field length in bits
	logic       err_hit;
	err_kind_t  err_kind_d;

	// ====================
	// Strobes to the other blocks
	// ====================

	always_comb
	begin
		stuff_region = field inside {field_id_a, field_rtr_srr, field_ide, field_id_b,
			field_rtr, field_res1, field_res0, field_dlc, field_data, field_crc,
			field_crc_del};
	end

	assign crc_clear = (field == field_idle);
	// Identifier through the last CRC bit
	assign crc_shift = data_strobe & stuff_region & (field != field_crc_del);

	// Outside the stuffing region every sample point is a frame bit
	assign bit_tick     = data_strobe;
	assign field_strobe = bit_tick & (field != field_idle) & (field != field_error);
	assign frame_start  = sample_point & (field == field_idle) & ~bit_value;
	assign frame_done   = sample_point & (field == field_eof) & field_last & bit_value;

	// DLC of 1xxx reads as eight bytes
	assign dlc_shift   = {dlc[`CAN_LEN_DLC-2:0], bit_value};
	assign dlc_clamped = dlc_shift[`CAN_LEN_DLC-1] ? dlc_t'(`CAN_MAX_DATA_BYTES) : dlc_shift;
	assign data_bits   = {dlc, 3'b000};

	// ====================
	// Field lengths and order
	// ====================

	always_comb
	begin
		case (field)
			field_id_a:         field_last = (bit_cnt == 6'(`CAN_LEN_ID_A - 1));
			field_id_b:         field_last = (bit_cnt == 6'(`CAN_LEN_ID_B - 1));
			field_dlc:          field_last = (bit_cnt == 6'(`CAN_LEN_DLC - 1));
			field_data:         field_last = ({1'b0, bit_cnt} == data_bits - 7'd1);
			field_crc:          field_last = (bit_cnt == 6'(`CAN_LEN_CRC - 1));
			field_eof:          field_last = (bit_cnt == 6'(`CAN_LEN_EOF - 1));
			field_intermission: field_last = (bit_cnt == 6'(`CAN_LEN_INTERMISSION - 1));
			field_error:        field_last = (bit_cnt == 6'(`CAN_BUS_IDLE_BITS - 1));
			default:            field_last = 1'b1;      // Single bit fields and idle
		endcase
	end

	always_comb
	begin
		case (field)
			field_idle:     next_field = bit_value ? field_idle : field_id_a;   // SOF
			field_id_a:     next_field = field_rtr_srr;
			field_rtr_srr:  next_field = field_ide;
			field_ide:      next_field = bit_value ? field_id_b : field_res0;
			field_id_b:     next_field = field_rtr;
			field_rtr:      next_field = field_res1;
			field_res1:     next_field = field_res0;
			field_res0:     next_field = field_dlc;
			// Remote or empty frames skip the data field
			field_dlc:      next_field = (rtr_q || dlc_clamped == '0) ? field_crc : field_data;
			field_data:     next_field = field_crc;
			field_crc:      next_field = field_crc_del;
			field_crc_del:  next_field = field_ack_slot;
			field_ack_slot: next_field = field_ack_del;
			field_ack_del:  next_field = field_eof;
			field_eof:      next_field = field_intermission;
			default:        next_field = field_idle;
		endcase
	end

	// ====================
	// Error detection
	// ====================

	always_comb
	begin
		err_hit    = 1'b0;
		err_kind_d = err_stuff;
		if (stuff_error)
			err_hit = 1'b1;     // Sixth equal bit
		else if (sample_point)
		begin
			case (field)
				field_crc_del:
				begin
					// A dominant stuff bit here is legal
					if (data_strobe && !bit_value)
					begin
						err_hit    = 1'b1;
						err_kind_d = err_form;
					end
				end
				field_ack_slot:
				begin
					if (bit_value)
					begin
						err_hit    = 1'b1;      // Nobody acknowledged
						err_kind_d = err_ack;
					end
				end
				field_ack_del:
				begin
					if (!bit_value)
					begin
						err_hit    = 1'b1;
						err_kind_d = err_form;
					end
					else if (!crc_zero)
					begin
						err_hit    = 1'b1;      // CRC checked at the ACK delimiter
						err_kind_d = err_crc;
					end
				end
				field_eof, field_intermission:
				begin
					if (!bit_value)
					begin
						err_hit    = 1'b1;      // No overload frames here
						err_kind_d = err_form;
					end
				end
				default: ;
			endcase
		end
	end

	// ====================
	// State and counters
	// ====================

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			field       <= field_idle;
			bit_cnt     <= '0;
			rtr_q       <= 1'b0;
			dlc         <= '0;
			error_valid <= 1'b0;
			error_kind  <= err_stuff;
		end
		else
		begin
			error_valid <= err_hit;     // One cycle report
			if (err_hit)
			begin
				error_kind <= err_kind_d;
				field      <= field_error;
				bit_cnt    <= '0;
			end
			else if (field == field_error)
			begin
				if (sample_point)
				begin
					if (!bit_value)
						bit_cnt <= '0;      // Dominant restarts the idle count
					else if (field_last)
					begin
						field   <= field_idle;
						bit_cnt <= '0;
					end
					else
						bit_cnt <= bit_cnt + 6'd1;
				end
			end
			else if (bit_tick)
			begin
				if (field_last)
				begin
					field   <= next_field;
					bit_cnt <= '0;
				end
				else
					bit_cnt <= bit_cnt + 6'd1;

				// Extended RTR overwrites the SRR bit
				if (field == field_rtr_srr || field == field_rtr)
					rtr_q <= bit_value;
				if (field == field_dlc)
					dlc <= field_last ? dlc_clamped : dlc_shift;
			end
		end
	end

endmodule

`default_nettype wire

// ==== hw/can_frame_capture.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "can_macros.svh"

module can_frame_capture (
	input  logic            clock,
	input  logic            reset,
	input  logic            bit_value,
	input  can_pkg::field_t field,
	input  logic            field_strobe,
	input  logic            frame_start,
	input  logic            frame_done,
	input  can_pkg::dlc_t   dlc,
	input  logic            frame_ack,
	output logic            frame_req,
	output can_pkg::id_a_t  id_a,
	output can_pkg::id_b_t  id_b,
	output logic            ide,
	output logic            rtr,
	output can_pkg::dlc_t   dlc_out,
	output can_pkg::data_t  data_out,
	output logic            overrun
);
	import can_pkg::*;

	// Working copies filled while the frame is on the bus
	id_a_t id_a_w;
	id_b_t id_b_w;
	logic  ide_w;
	logic  rtr_w;
	data_t data_w;

	logic  hs_busy;     // Consumer still holds the last frame
	logic  take;        // Frame finished and output free

	assign hs_busy = frame_req | frame_ack;
	assign take    = frame_done & ~hs_busy;

	// ====================
	// Working registers
	// ====================

	always_ff @(posedge clock)
	begin
		if (frame_start)
		begin
			// Cleared so short frames read back zero upper data
			id_a_w <= '0;
			id_b_w <= '0;
			ide_w  <= 1'b0;
			rtr_w  <= 1'b0;
			data_w <= '0;
		end
		else if (field_strobe)
		begin
			case (field)
				field_id_a:
					id_a_w <= {id_a_w[`CAN_LEN_ID_A-2:0], bit_value};
				field_rtr_srr, field_rtr:
					rtr_w <= bit_value;     // Base RTR, then extended RTR
				field_ide:
					ide_w <= bit_value;
				field_id_b:
					id_b_w <= {id_b_w[`CAN_LEN_ID_B-2:0], bit_value};
				field_data:
					data_w <= {data_w[`CAN_MAX_DATA_BYTES*8-2:0], bit_value};
				default: ;
			endcase
		end
	end

	// ====================
	// Output fields
	// ====================

	// Stable for as long as frame_req is high
	always_ff @(posedge clock)
	begin
		if (take)
		begin
			id_a     <= id_a_w;
			id_b     <= id_b_w;
			ide      <= ide_w;
			rtr      <= rtr_w;
			dlc_out  <= dlc;
			data_out <= data_w;
		end
	end

	// ====================
	// Four phase handshake
	// ====================

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			frame_req <= 1'b0;
			overrun   <= 1'b0;
		end
		else
		begin
			overrun <= frame_done & hs_busy;   // New frame dropped, held one kept
			if (take)
				frame_req <= 1'b1;
			else if (frame_ack)
				frame_req <= 1'b0;              // Ack seen, release request
		end
	end

endmodule

`default_nettype wire

// ==== hw/can_macros.svh ====
`ifndef CAN_MACROS_SVH
`define CAN_MACROS_SVH

// ====================
// Frame field lengths
// ====================

// Base identifier and extension
`define CAN_LEN_ID_A 11
`define CAN_LEN_ID_B 18

`define CAN_LEN_DLC 4
`define CAN_LEN_CRC 15
`define CAN_LEN_EOF 7

// Third recessive bit may already be the next start of frame
`define CAN_LEN_INTERMISSION 2

// ====================
// Bus timing and coding
// ====================

// Equal bits that force a stuff bit
`define CAN_STUFF_RUN 5

// Recessive run needed to leave error recovery
`define CAN_BUS_IDLE_BITS 11

`define CAN_MAX_DATA_BYTES 8
`define CAN_CRC_POLY 15'h4599

`endif

// ==== hw/can_pkg.sv ====
`default_nettype none

`include "can_macros.svh"

package can_pkg;

	// ====================
	// Frame fields
	// ====================

	typedef logic [`CAN_LEN_ID_A-1:0] id_a_t;                // Base ID
	typedef logic [`CAN_LEN_ID_B-1:0] id_b_t;                // Extension ID
	typedef logic [`CAN_LEN_DLC-1:0] dlc_t;
	typedef logic [`CAN_MAX_DATA_BYTES*8-1:0] data_t;      // Right aligned payload
	typedef logic [`CAN_LEN_CRC-1:0] crc_t;

	// ====================
	// Sequencer states
	// ====================

	// One state per frame field, in bus order
	typedef enum logic [4:0] {
		field_idle,
		field_id_a,
		field_rtr_srr,      // RTR in base frames, SRR in extended
		field_ide,
		field_id_b,
		field_rtr,          // Extended frames only
		field_res1,
		field_res0,
		field_dlc,
		field_data,
		field_crc,
		field_crc_del,
		field_ack_slot,
		field_ack_del,
		field_eof,
		field_intermission,
		field_error         // Waiting for bus idle
	} field_t;

	// Reported error kinds
	typedef enum logic [1:0] {
		err_stuff,
		err_form,
		err_ack,
		err_crc
	} err_kind_t;

endpackage

`default_nettype wire

// ==== hw/can_rx.sv ====
`timescale 1ns/1ps
`default_nettype none

module can_rx (
	input  logic               clock,
	input  logic               reset,
	input  logic               rx_bit,
	input  logic               sample_point,
	input  logic               frame_ack,
	output logic               frame_req,
	output can_pkg::id_a_t     id_a,
	output can_pkg::id_b_t     id_b,
	output logic               ide,
	output logic               rtr,
	output can_pkg::dlc_t      dlc_out,
	output can_pkg::data_t     data_out,
	output logic               overrun,
	output logic               error_valid,
	output can_pkg::err_kind_t error_kind
);
	import can_pkg::*;

	// Destuffer outputs
	logic   data_strobe;
	logic   stuff_error;
	logic   bit_value;

	// Sequencer control
	logic   stuff_region;
	logic   crc_clear;
	logic   crc_shift;
	logic   crc_zero;
	field_t field;
	logic   field_strobe;
	logic   frame_start;
	logic   frame_done;
	dlc_t   dlc;

	// ====================
	// Bit level
	// ====================

	can_bit_destuff destuff_i (
		.clock        (clock),
		.reset        (reset),
		.rx_bit       (rx_bit),
		.sample_point (sample_point),
		.stuff_region (stuff_region),
		.data_strobe  (data_strobe),
		.stuff_error  (stuff_error),
		.bit_value    (bit_value)
	);

	can_crc15 crc_i (
		.clock     (clock),
		.reset     (reset),
		.crc_clear (crc_clear),
		.crc_shift (crc_shift),
		.bit_value (bit_value),
		.crc_zero  (crc_zero)
	);

	// ====================
	// Frame level
	// ====================

	can_field_sequencer sequencer_i (
		.clock        (clock),
		.reset        (reset),
		.sample_point (sample_point),
		.bit_value    (bit_value),
		.data_strobe  (data_strobe),
		.stuff_error  (stuff_error),
		.crc_zero     (crc_zero),
		.stuff_region (stuff_region),
		.crc_clear    (crc_clear),
		.crc_shift    (crc_shift),
		.field        (field),
		.field_strobe (field_strobe),
		.frame_start  (frame_start),
		.frame_done   (frame_done),
		.dlc          (dlc),
		.error_valid  (error_valid),    // Straight to the outputs
		.error_kind   (error_kind)
	);

	can_frame_capture capture_i (
		.clock        (clock),
		.reset        (reset),
		.bit_value    (bit_value),
		.field        (field),
		.field_strobe (field_strobe),
		.frame_start  (frame_start),
		.frame_done   (frame_done),
		.dlc          (dlc),
		.frame_ack    (frame_ack),
		.frame_req    (frame_req),
		.id_a         (id_a),
		.id_b         (id_b),
		.ide          (ide),
		.rtr          (rtr),
		.dlc_out      (dlc_out),
		.data_out     (data_out),
		.overrun      (overrun)
	);

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module can_rx_tb \
	-f can_rx.f -o can_rx_sim \
	&& ./obj_dir/can_rx_sim | tee /dev/stderr | grep -q -F "Finished with no errors" \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }
